// ==== design/layer_ctrl_pkg.sv ====
package layer_ctrl_pkg;

  // core array and datapath widths
  localparam int NUM_CORES = 4;
  localparam int DATA_W    = 16;
  localparam int DIM_W     = 8;
  localparam int IMG_AW    = 12;
  localparam int NET_AW    = 10;

  typedef logic signed [DATA_W-1:0]      data_t;
  typedef logic [DIM_W-1:0]              dim_t;
  typedef logic [IMG_AW-1:0]             img_addr_t;
  typedef logic [NET_AW-1:0]             net_addr_t;
  typedef logic [$clog2(NUM_CORES)-1:0]  core_idx_t;

  // apb word address and data
  typedef logic [3:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  //====================================================================
  // register map
  //====================================================================
  localparam apb_addr_t REG_CTRL       = 4'd0;
  localparam apb_addr_t REG_STATUS     = 4'd1;
  localparam apb_addr_t REG_IN_OFFSET  = 4'd2;
  localparam apb_addr_t REG_OUT_OFFSET = 4'd3;
  localparam apb_addr_t REG_NET_OFFSET = 4'd4;
  localparam apb_addr_t REG_TOTAL_IN   = 4'd5;
  localparam apb_addr_t REG_TOTAL_OUT  = 4'd6;
  localparam apb_addr_t REG_HEIGHT     = 4'd7;
  localparam apb_addr_t REG_WIDTH      = 4'd8;
  localparam apb_addr_t REG_KERN       = 4'd9;

  // layer phases
  typedef enum logic [1:0] {
    PH_WAIT    = 2'd0,
    PH_NETWORK = 2'd1,
    PH_INPUT   = 2'd2,
    PH_OUTPUT  = 2'd3
  } phase_t;

endpackage

// ==== design/apb_cfg_regs.sv ====
`timescale 1ns/1ps

module apb_cfg_regs (
  input  logic                      clk,
  input  logic                      xrst,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  layer_ctrl_pkg::apb_addr_t paddr,
  input  layer_ctrl_pkg::apb_data_t pwdata,
  output layer_ctrl_pkg::apb_data_t prdata,
  output logic                      pready,
  output logic                      pslverr,
  input  logic                      busy,
  output logic                      start,
  output layer_ctrl_pkg::img_addr_t in_offset,
  output layer_ctrl_pkg::img_addr_t out_offset,
  output layer_ctrl_pkg::net_addr_t net_offset,
  output layer_ctrl_pkg::dim_t      total_in,
  output layer_ctrl_pkg::dim_t      total_out,
  output layer_ctrl_pkg::dim_t      height,
  output layer_ctrl_pkg::dim_t      width,
  output layer_ctrl_pkg::dim_t      kern
);

  logic access;
  logic mapped;
  logic locked;
  logic wr_en;

  assign access = psel && penable;
  assign mapped = paddr <= layer_ctrl_pkg::REG_KERN;
  // only ctrl stays writable while a job runs
  assign locked = busy && paddr != layer_ctrl_pkg::REG_CTRL;

  // zero wait states
  assign pready  = 1'b1;
  assign pslverr = access && (!mapped || (pwrite && locked));
  assign wr_en   = access && pwrite && !pslverr;

  // start pulse lasts exactly the access phase
  assign start = wr_en && paddr == layer_ctrl_pkg::REG_CTRL && pwdata[0] && !busy;

  //====================================================================
  // configuration registers
  //====================================================================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      in_offset  <= '0;
      out_offset <= '0;
      net_offset <= '0;
      total_in   <= '0;
      total_out  <= '0;
      height     <= '0;
      width      <= '0;
      kern       <= '0;
    end else if (wr_en) begin
      case (paddr)
        layer_ctrl_pkg::REG_IN_OFFSET:  in_offset  <= pwdata[layer_ctrl_pkg::IMG_AW-1:0];
        layer_ctrl_pkg::REG_OUT_OFFSET: out_offset <= pwdata[layer_ctrl_pkg::IMG_AW-1:0];
        layer_ctrl_pkg::REG_NET_OFFSET: net_offset <= pwdata[layer_ctrl_pkg::NET_AW-1:0];
        layer_ctrl_pkg::REG_TOTAL_IN:   total_in   <= pwdata[layer_ctrl_pkg::DIM_W-1:0];
        layer_ctrl_pkg::REG_TOTAL_OUT:  total_out  <= pwdata[layer_ctrl_pkg::DIM_W-1:0];
        layer_ctrl_pkg::REG_HEIGHT:     height     <= pwdata[layer_ctrl_pkg::DIM_W-1:0];
        layer_ctrl_pkg::REG_WIDTH:      width      <= pwdata[layer_ctrl_pkg::DIM_W-1:0];
        layer_ctrl_pkg::REG_KERN:       kern       <= pwdata[layer_ctrl_pkg::DIM_W-1:0];
        default: ;
      endcase
    end
  end

  // ctrl and unmapped addresses read back as zero
  always_comb begin
    prdata = '0;
    case (paddr)
      layer_ctrl_pkg::REG_STATUS:     prdata = layer_ctrl_pkg::apb_data_t'(busy);
      layer_ctrl_pkg::REG_IN_OFFSET:  prdata = layer_ctrl_pkg::apb_data_t'(in_offset);
      layer_ctrl_pkg::REG_OUT_OFFSET: prdata = layer_ctrl_pkg::apb_data_t'(out_offset);
      layer_ctrl_pkg::REG_NET_OFFSET: prdata = layer_ctrl_pkg::apb_data_t'(net_offset);
      layer_ctrl_pkg::REG_TOTAL_IN:   prdata = layer_ctrl_pkg::apb_data_t'(total_in);
      layer_ctrl_pkg::REG_TOTAL_OUT:  prdata = layer_ctrl_pkg::apb_data_t'(total_out);
      layer_ctrl_pkg::REG_HEIGHT:     prdata = layer_ctrl_pkg::apb_data_t'(height);
      layer_ctrl_pkg::REG_WIDTH:      prdata = layer_ctrl_pkg::apb_data_t'(width);
      layer_ctrl_pkg::REG_KERN:       prdata = layer_ctrl_pkg::apb_data_t'(kern);
      default: ;
    endcase
  end

endmodule

// ==== design/layer_sequencer.sv ====
`timescale 1ns/1ps

module layer_sequencer (
  input  logic                   clk,
  input  logic                   xrst,
  input  logic                   start,
  input  layer_ctrl_pkg::dim_t   total_in,
  input  layer_ctrl_pkg::dim_t   total_out,
  input  logic                   net_done,
  input  logic                   in_done,
  input  logic                   out_done,
  output layer_ctrl_pkg::phase_t phase,
  output logic                   first_input,
  output logic                   last_input,
  output logic                   busy
);

  layer_ctrl_pkg::dim_t           count_in;
  layer_ctrl_pkg::dim_t           count_out;
  logic [layer_ctrl_pkg::DIM_W:0] next_out;
  logic                           in_channel;
  logic                           in_last;
  logic                           group_last;

  assign in_last = count_in == total_in - layer_ctrl_pkg::dim_t'(1);

  // one extra bit so the last group compare cannot wrap
  assign next_out   = {1'b0, count_out}
                    + (layer_ctrl_pkg::DIM_W + 1)'(layer_ctrl_pkg::NUM_CORES);
  assign group_last = next_out >= {1'b0, total_out};

  // channel marks hold through network and input phases
  assign in_channel  = phase == layer_ctrl_pkg::PH_NETWORK
                    || phase == layer_ctrl_pkg::PH_INPUT;
  assign first_input = in_channel && count_in == '0;
  assign last_input  = in_channel && in_last;
  assign busy        = phase != layer_ctrl_pkg::PH_WAIT;

  //====================================================================
  // main phase FSM
  //====================================================================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      phase     <= layer_ctrl_pkg::PH_WAIT;
      count_in  <= '0;
      count_out <= '0;
    end else begin
      case (phase)
        layer_ctrl_pkg::PH_WAIT:
          if (start) begin
            phase     <= layer_ctrl_pkg::PH_NETWORK;
            count_in  <= '0;
            count_out <= '0;
          end
        layer_ctrl_pkg::PH_NETWORK:
          if (net_done)
            phase <= layer_ctrl_pkg::PH_INPUT;
        layer_ctrl_pkg::PH_INPUT:
          if (in_done) begin
            if (in_last) begin
              phase    <= layer_ctrl_pkg::PH_OUTPUT;
              count_in <= '0;
            end else begin
              phase    <= layer_ctrl_pkg::PH_NETWORK;
              count_in <= count_in + layer_ctrl_pkg::dim_t'(1);
            end
          end
        layer_ctrl_pkg::PH_OUTPUT:
          if (out_done) begin
            if (group_last) begin
              phase     <= layer_ctrl_pkg::PH_WAIT;
              count_out <= '0;
            end else begin
              phase     <= layer_ctrl_pkg::PH_NETWORK;
              count_out <= next_out[layer_ctrl_pkg::DIM_W-1:0];
            end
          end
        default:
          phase <= layer_ctrl_pkg::PH_WAIT;
      endcase
    end
  end

endmodule

// ==== design/weight_fetch.sv ====
`timescale 1ns/1ps

module weight_fetch (
  input  logic                      clk,
  input  logic                      xrst,
  input  layer_ctrl_pkg::phase_t    phase,
  input  logic                      last_input,
  input  layer_ctrl_pkg::dim_t      kern,
  input  layer_ctrl_pkg::net_addr_t net_offset,
  output logic                      net_re,
  output layer_ctrl_pkg::net_addr_t net_addr,
  output logic                      wreg_we,
  output logic                      breg_we,
  output logic                      net_done
);

  typedef enum logic {
    WB_WEIGHT,
    WB_BIAS
  } wb_state_t;

  wb_state_t                 sub;
  layer_ctrl_pkg::dim_t      col;
  layer_ctrl_pkg::dim_t      row;
  layer_ctrl_pkg::dim_t      kern_last;
  layer_ctrl_pkg::net_addr_t cnt;
  logic                      weight_last;
  logic                      read_last;

  assign kern_last   = kern - layer_ctrl_pkg::dim_t'(1);
  assign weight_last = sub == WB_WEIGHT && col == kern_last && row == kern_last;
  // bias read follows the weights only on the last channel
  assign read_last   = net_re && (sub == WB_BIAS || (weight_last && !last_input));
  assign net_done    = read_last;
  assign net_addr    = cnt + net_offset;

  // read strobe and data strobes one cycle behind
  always_ff @(posedge clk) begin
    if (!xrst) begin
      net_re  <= 1'b0;
      wreg_we <= 1'b0;
      breg_we <= 1'b0;
    end else begin
      net_re  <= phase == layer_ctrl_pkg::PH_NETWORK && !read_last;
      wreg_we <= net_re && sub == WB_WEIGHT;
      breg_we <= net_re && sub == WB_BIAS;
    end
  end

  // running address over the whole job
  always_ff @(posedge clk) begin
    if (!xrst || phase == layer_ctrl_pkg::PH_WAIT)
      cnt <= '0;
    else if (net_re)
      cnt <= cnt + layer_ctrl_pkg::net_addr_t'(1);
  end

  //====================================================================
  // kernel walk
  //====================================================================
  always_ff @(posedge clk) begin
    if (!xrst || phase != layer_ctrl_pkg::PH_NETWORK) begin
      col <= '0;
      row <= '0;
      sub <= WB_WEIGHT;
    end else if (net_re) begin
      if (sub == WB_BIAS) begin
        sub <= WB_WEIGHT;
      end else if (col == kern_last) begin
        col <= '0;
        if (row == kern_last) begin
          row <= '0;
          if (last_input)
            sub <= WB_BIAS;
        end else begin
          row <= row + layer_ctrl_pkg::dim_t'(1);
        end
      end else begin
        col <= col + layer_ctrl_pkg::dim_t'(1);
      end
    end
  end

endmodule

// ==== design/image_port.sv ====
`timescale 1ns/1ps

module image_port (
  input  logic                       clk,
  input  logic                       xrst,
  input  layer_ctrl_pkg::phase_t     phase,
  input  layer_ctrl_pkg::dim_t       height,
  input  layer_ctrl_pkg::dim_t       width,
  input  layer_ctrl_pkg::img_addr_t  in_offset,
  input  layer_ctrl_pkg::img_addr_t  out_offset,
  input  layer_ctrl_pkg::data_t      out_wdata,
  output logic                       img_re,
  output logic                       img_we,
  output layer_ctrl_pkg::img_addr_t  img_addr,
  output layer_ctrl_pkg::data_t      img_wdata,
  output logic                       pix_valid,
  output layer_ctrl_pkg::core_idx_t  out_sel,
  output layer_ctrl_pkg::img_addr_t  out_pix,
  output logic                       in_done,
  output logic                       out_done
);

  layer_ctrl_pkg::dim_t      col;
  layer_ctrl_pkg::dim_t      row;
  layer_ctrl_pkg::img_addr_t rd_ptr;
  layer_ctrl_pkg::img_addr_t wr_ptr;
  layer_ctrl_pkg::img_addr_t plane_last;
  logic                      rd_last;
  logic                      wr_last;

  assign plane_last = layer_ctrl_pkg::img_addr_t'(height)
                    * layer_ctrl_pkg::img_addr_t'(width)
                    - layer_ctrl_pkg::img_addr_t'(1);

  assign rd_last = img_re
                && col == width - layer_ctrl_pkg::dim_t'(1)
                && row == height - layer_ctrl_pkg::dim_t'(1);
  assign wr_last = img_we && out_pix == plane_last
                && out_sel == layer_ctrl_pkg::core_idx_t'(layer_ctrl_pkg::NUM_CORES - 1);

  assign in_done  = rd_last;
  assign out_done = wr_last;

  // reads and writes never share a phase
  assign img_addr  = img_we ? wr_ptr : rd_ptr;
  assign img_wdata = out_wdata;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      img_re    <= 1'b0;
      img_we    <= 1'b0;
      pix_valid <= 1'b0;
    end else begin
      img_re    <= phase == layer_ctrl_pkg::PH_INPUT && !rd_last;
      img_we    <= phase == layer_ctrl_pkg::PH_OUTPUT && !wr_last;
      pix_valid <= img_re;
    end
  end

  //====================================================================
  // input plane walk
  //====================================================================
  always_ff @(posedge clk) begin
    if (!xrst || phase != layer_ctrl_pkg::PH_INPUT) begin
      col <= '0;
      row <= '0;
    end else if (img_re) begin
      if (col == width - layer_ctrl_pkg::dim_t'(1)) begin
        col <= '0;
        row <= row + layer_ctrl_pkg::dim_t'(1);
      end else begin
        col <= col + layer_ctrl_pkg::dim_t'(1);
      end
    end
  end

  // every group rereads all input planes from in_offset
  always_ff @(posedge clk) begin
    if (!xrst || phase == layer_ctrl_pkg::PH_WAIT || phase == layer_ctrl_pkg::PH_OUTPUT)
      rd_ptr <= in_offset;
    else if (img_re)
      rd_ptr <= rd_ptr + layer_ctrl_pkg::img_addr_t'(1);
  end

  //====================================================================
  // result write-back
  //====================================================================
  always_ff @(posedge clk) begin
    if (!xrst || phase != layer_ctrl_pkg::PH_OUTPUT) begin
      out_sel <= '0;
      out_pix <= '0;
    end else if (img_we) begin
      if (out_pix == plane_last) begin
        out_pix <= '0;
        out_sel <= out_sel + layer_ctrl_pkg::core_idx_t'(1);
      end else begin
        out_pix <= out_pix + layer_ctrl_pkg::img_addr_t'(1);
      end
    end
  end

  // output planes are packed back to back for the whole job
  always_ff @(posedge clk) begin
    if (!xrst || phase == layer_ctrl_pkg::PH_WAIT)
      wr_ptr <= out_offset;
    else if (img_we)
      wr_ptr <= wr_ptr + layer_ctrl_pkg::img_addr_t'(1);
  end

endmodule

// ==== design/layer_ctrl_top.sv ====
`timescale 1ns/1ps

module layer_ctrl_top (
  input  logic                      clk,
  input  logic                      xrst,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  layer_ctrl_pkg::apb_addr_t paddr,
  input  layer_ctrl_pkg::apb_data_t pwdata,
  output layer_ctrl_pkg::apb_data_t prdata,
  output logic                      pready,
  output logic                      pslverr,
  output logic                      busy,
  output logic                      net_re,
  output layer_ctrl_pkg::net_addr_t net_addr,
  input  layer_ctrl_pkg::data_t     net_rdata,
  output logic                      wreg_we,
  output logic                      breg_we,
  output logic                      first_input,
  output logic                      last_input,
  output logic                      img_re,
  output logic                      img_we,
  output layer_ctrl_pkg::img_addr_t img_addr,
  output layer_ctrl_pkg::data_t     img_wdata,
  input  layer_ctrl_pkg::data_t     img_rdata,
  output logic                      pix_valid,
  output layer_ctrl_pkg::core_idx_t out_sel,
  output layer_ctrl_pkg::img_addr_t out_pix,
  input  layer_ctrl_pkg::data_t     out_wdata,
  output layer_ctrl_pkg::data_t     core_data
);

  logic                      start;
  layer_ctrl_pkg::img_addr_t in_offset;
  layer_ctrl_pkg::img_addr_t out_offset;
  layer_ctrl_pkg::net_addr_t net_offset;
  layer_ctrl_pkg::dim_t      total_in;
  layer_ctrl_pkg::dim_t      total_out;
  layer_ctrl_pkg::dim_t      height;
  layer_ctrl_pkg::dim_t      width;
  layer_ctrl_pkg::dim_t      kern;
  layer_ctrl_pkg::phase_t    phase;
  logic                      net_done;
  logic                      in_done;
  logic                      out_done;

  // weights and bias share the core bus with pixels
  assign core_data = (wreg_we || breg_we) ? net_rdata : img_rdata;

  apb_cfg_regs u_regs (
    .clk, .xrst, .psel, .penable, .pwrite, .paddr, .pwdata,
    .prdata, .pready, .pslverr, .busy, .start,
    .in_offset, .out_offset, .net_offset,
    .total_in, .total_out, .height, .width, .kern
  );

  layer_sequencer u_seq (
    .clk, .xrst, .start, .total_in, .total_out,
    .net_done, .in_done, .out_done,
    .phase, .first_input, .last_input, .busy
  );

  weight_fetch u_wfetch (
    .clk, .xrst, .phase, .last_input, .kern, .net_offset,
    .net_re, .net_addr, .wreg_we, .breg_we, .net_done
  );

  image_port u_iport (
    .clk, .xrst, .phase, .height, .width, .in_offset, .out_offset,
    .out_wdata, .img_re, .img_we, .img_addr, .img_wdata, .pix_valid,
    .out_sel, .out_pix, .in_done, .out_done
  );

endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk
);

  // 4 ns period
  localparam int HALF_NS = 2;

  initial clk = 1'b0;

  always #HALF_NS clk = ~clk;

endmodule

// ==== tb/layer_ctrl_asserts.sv ====
`timescale 1ns/1ps

module layer_ctrl_asserts (
  input logic clk,
  input logic xrst,
  input logic pready,
  input logic wreg_we,
  input logic breg_we,
  input logic img_re,
  input logic img_we,
  input logic pix_valid
);

  // weight and bias strobes share the core data bus
  strobe_excl: assert property (@(posedge clk) disable iff (!xrst) !(wreg_we && breg_we))
    else $error("weight and bias strobes high in the same cycle");

  // single image memory port
  port_excl: assert property (@(posedge clk) disable iff (!xrst) !(img_re && img_we))
    else $error("image read and write in the same cycle");

  ready_high: assert property (@(posedge clk) disable iff (!xrst) pready)
    else $error("pready went low");

  // one cycle read latency
  valid_rise: assert property (@(posedge clk) disable iff (!xrst) img_re |=> pix_valid)
    else $error("pix_valid missing one cycle after img_re");
  valid_fall: assert property (@(posedge clk) disable iff (!xrst) !img_re |=> !pix_valid)
    else $error("pix_valid without a read one cycle before");

endmodule

// ==== tb/tb_layer_ctrl.sv ====
`timescale 1ns/1ps

module tb_layer_ctrl;

  localparam int CLK_NS   = 4;
  localparam int NUM_ROWS = 5;
  // about 20 apb accesses of 3 cycles per row
  localparam int ACCESS_CYCLES = 64;

  // stimulus table columns
  localparam int C_IN_OFS    = 0;
  localparam int C_OUT_OFS   = 1;
  localparam int C_NET_OFS   = 2;
  localparam int C_TOTAL_IN  = 3;
  localparam int C_TOTAL_OUT = 4;
  localparam int C_HEIGHT    = 5;
  localparam int C_WIDTH     = 6;
  localparam int C_KERN      = 7;
  localparam int C_GROUPS    = 8;

  // in_ofs, out_ofs, net_ofs, total_in, total_out, height, width, kern, expected groups
  int rows [NUM_ROWS][9] = '{
    '{  16,  512,   0, 1, 4, 3, 3, 1, 1},
    '{ 100, 1000,  50, 2, 6, 4, 5, 3, 2},
    '{   0, 2048, 200, 3, 3, 2, 3, 3, 1},
    '{ 700, 3000, 300, 1, 9, 5, 2, 1, 3},
    '{1500, 1800, 600, 4, 5, 3, 4, 3, 2}
  };

  logic                      clk;
  logic                      xrst;
  logic                      psel;
  logic                      penable;
  logic                      pwrite;
  layer_ctrl_pkg::apb_addr_t paddr;
  layer_ctrl_pkg::apb_data_t pwdata;
  layer_ctrl_pkg::apb_data_t prdata;
  logic                      pready;
  logic                      pslverr;
  logic                      busy;
  logic                      net_re;
  layer_ctrl_pkg::net_addr_t net_addr;
  layer_ctrl_pkg::data_t     net_rdata = '0;
  logic                      wreg_we;
  logic                      breg_we;
  logic                      first_input;
  logic                      last_input;
  logic                      img_re;
  logic                      img_we;
  layer_ctrl_pkg::img_addr_t img_addr;
  layer_ctrl_pkg::data_t     img_wdata;
  layer_ctrl_pkg::data_t     img_rdata = '0;
  logic                      pix_valid;
  layer_ctrl_pkg::core_idx_t out_sel;
  layer_ctrl_pkg::img_addr_t out_pix;
  layer_ctrl_pkg::data_t     out_wdata;
  layer_ctrl_pkg::data_t     core_data;

  // current row as seen by the monitor
  int cur_in_ofs;
  int cur_out_ofs;
  int cur_net_ofs;
  int cur_total_in;
  int cur_plane;

  // event counts of one job
  int net_cnt = 0;
  int wreg_cnt = 0;
  int bias_cnt = 0;
  int first_cnt = 0;
  int last_cnt = 0;
  int rd_cnt = 0;
  int pix_cnt = 0;
  int wr_cnt = 0;
  logic busy_q = 1'b0;

  int reg_errors = 0;
  int stream_errors = 0;
  int count_errors = 0;

  tb_clock_gen u_clk (.clk(clk));

  layer_ctrl_top uut (.*);

  bind layer_ctrl_top layer_ctrl_asserts u_asserts (
    .clk(clk), .xrst(xrst), .pready(pready), .wreg_we(wreg_we), .breg_we(breg_we),
    .img_re(img_re), .img_we(img_we), .pix_valid(pix_valid)
  );

  // core model answers combinationally
  assign out_wdata = layer_ctrl_pkg::data_t'(int'(out_sel) * 1000 + int'(out_pix));

  task automatic check_value(input string what, input int expected, input int actual,
                             inout int errors);
    assert (actual == expected)
      else begin
        $display("Fail %s: expected %0d, actual %0d", what, expected, actual);
        errors++;
      end
  endtask

  task automatic write_reg(input layer_ctrl_pkg::apb_addr_t addr, input int value,
                           output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = layer_ctrl_pkg::apb_data_t'(value);
    @(negedge clk);
    penable = 1'b1;
    #1;
    err = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_reg(input layer_ctrl_pkg::apb_addr_t addr,
                          output layer_ctrl_pkg::apb_data_t data, output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    #1;
    data = prdata;
    err  = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  //======================================================================
  // program one table row, run it and compare its counts
  //======================================================================
  task automatic run_row(input int r);
    logic                      err;
    layer_ctrl_pkg::apb_data_t data;
    layer_ctrl_pkg::apb_addr_t addr;
    int                        groups;
    int                        k2;
    cur_in_ofs   = rows[r][C_IN_OFS];
    cur_out_ofs  = rows[r][C_OUT_OFS];
    cur_net_ofs  = rows[r][C_NET_OFS];
    cur_total_in = rows[r][C_TOTAL_IN];
    cur_plane    = rows[r][C_HEIGHT] * rows[r][C_WIDTH];
    groups       = rows[r][C_GROUPS];
    k2           = rows[r][C_KERN] * rows[r][C_KERN];
    // config registers sit in table column order
    for (int c = 0; c <= C_KERN; c++) begin
      addr = layer_ctrl_pkg::apb_addr_t'(int'(layer_ctrl_pkg::REG_IN_OFFSET) + c);
      write_reg(addr, rows[r][c], err);
      check_value($sformatf("row %0d reg %0d pslverr on write", r, c), 0, int'(err),
                  reg_errors);
    end
    for (int c = 0; c <= C_KERN; c++) begin
      addr = layer_ctrl_pkg::apb_addr_t'(int'(layer_ctrl_pkg::REG_IN_OFFSET) + c);
      read_reg(addr, data, err);
      check_value($sformatf("row %0d reg %0d readback", r, c), rows[r][c], int'(data),
                  reg_errors);
    end
    write_reg(layer_ctrl_pkg::REG_CTRL, 1, err);
    check_value($sformatf("row %0d busy after start", r), 1, int'(busy), reg_errors);
    // config is locked while busy
    write_reg(layer_ctrl_pkg::REG_KERN, rows[r][C_KERN] + 1, err);
    check_value($sformatf("row %0d pslverr on locked write", r), 1, int'(err), reg_errors);
    read_reg(layer_ctrl_pkg::REG_KERN, data, err);
    check_value($sformatf("row %0d kern after locked write", r), rows[r][C_KERN],
                int'(data), reg_errors);
    while (busy) @(negedge clk);
    read_reg(layer_ctrl_pkg::REG_STATUS, data, err);
    check_value($sformatf("row %0d status after job", r), 0, int'(data), reg_errors);
    check_value($sformatf("row %0d weight strobes", r), groups * cur_total_in * k2,
                wreg_cnt, count_errors);
    check_value($sformatf("row %0d bias strobes", r), groups, bias_cnt, count_errors);
    check_value($sformatf("row %0d first channel weights", r), groups * k2, first_cnt,
                count_errors);
    check_value($sformatf("row %0d last channel weights", r), groups * k2, last_cnt,
                count_errors);
    check_value($sformatf("row %0d image reads", r), groups * cur_total_in * cur_plane,
                rd_cnt, count_errors);
    check_value($sformatf("row %0d pixels", r), groups * cur_total_in * cur_plane,
                pix_cnt, count_errors);
    check_value($sformatf("row %0d result writes", r),
                groups * layer_ctrl_pkg::NUM_CORES * cur_plane, wr_cnt, count_errors);
  endtask

  //======================================================================
  // stream monitor and memory models
  //======================================================================
  always @(negedge clk) begin : monitor
    int span;
    int sel;
    int pix;
    if (busy && !busy_q) begin
      net_cnt   = 0;
      wreg_cnt  = 0;
      bias_cnt  = 0;
      first_cnt = 0;
      last_cnt  = 0;
      rd_cnt    = 0;
      pix_cnt   = 0;
      wr_cnt    = 0;
    end
    if (wreg_we || breg_we) begin
      check_value("network data", cur_net_ofs + net_cnt + 100, int'(core_data),
                  stream_errors);
      net_cnt++;
      if (wreg_we) begin
        wreg_cnt++;
        if (first_input)
          first_cnt++;
        if (last_input)
          last_cnt++;
      end else begin
        bias_cnt++;
      end
    end
    if (img_re) begin
      span = cur_total_in * cur_plane;
      check_value("image read address", cur_in_ofs + rd_cnt % span, int'(img_addr),
                  stream_errors);
      rd_cnt++;
    end
    if (pix_valid) begin
      span = cur_total_in * cur_plane;
      check_value("pixel data", cur_in_ofs + pix_cnt % span, int'(core_data),
                  stream_errors);
      pix_cnt++;
    end
    if (img_we) begin
      sel = (wr_cnt / cur_plane) % layer_ctrl_pkg::NUM_CORES;
      pix = wr_cnt % cur_plane;
      check_value("result write address", cur_out_ofs + wr_cnt, int'(img_addr),
                  stream_errors);
      check_value("result core select", sel, int'(out_sel), stream_errors);
      check_value("result data", sel * 1000 + pix, int'(img_wdata), stream_errors);
      wr_cnt++;
    end
    // read data seen at the next sample point
    net_rdata = net_re ? layer_ctrl_pkg::data_t'(net_addr) + 16'sd100 : '0;
    img_rdata = img_re ? layer_ctrl_pkg::data_t'(img_addr) : '0;
    busy_q    = busy;
  end

  initial begin : watchdog
    int limit;
    int groups;
    int plane;
    int k2;
    limit = 200;
    for (int r = 0; r < NUM_ROWS; r++) begin
      groups = (rows[r][C_TOTAL_OUT] + layer_ctrl_pkg::NUM_CORES - 1)
             / layer_ctrl_pkg::NUM_CORES;
      plane  = rows[r][C_HEIGHT] * rows[r][C_WIDTH];
      k2     = rows[r][C_KERN] * rows[r][C_KERN];
      limit += groups * (rows[r][C_TOTAL_IN] * (k2 + plane + 4) + 4 * plane + 4);
      limit += ACCESS_CYCLES;
    end
    #(limit * CLK_NS);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("*** FAILED ***");
    $finish;
  end

  initial begin : main
    logic                      err;
    layer_ctrl_pkg::apb_data_t data;
    int                        total;
    xrst    = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (5) @(negedge clk);
    xrst = 1'b1;
    @(negedge clk);
    check_value("outputs after reset", 0,
                int'({busy, net_re, wreg_we, breg_we, img_re, img_we, pix_valid,
                      first_input, last_input, pslverr}), reg_errors);
    read_reg(4'd15, data, err);
    check_value("pslverr on unmapped read", 1, int'(err), reg_errors);
    for (int r = 0; r < NUM_ROWS; r++)
      run_row(r);
    total = reg_errors + stream_errors + count_errors;
    $display("errors: register %0d, stream %0d, count %0d",
             reg_errors, stream_errors, count_errors);
    if (total == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
design/layer_ctrl_pkg.sv
design/apb_cfg_regs.sv
design/layer_sequencer.sv
design/weight_fetch.sv
design/image_port.sv
design/layer_ctrl_top.sv
tb/tb_clock_gen.sv
tb/layer_ctrl_asserts.sv
tb/tb_layer_ctrl.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the layer controller testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f sources.f --top-module tb_layer_ctrl \
  -o tb_layer_ctrl_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_layer_ctrl_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF '*** FAILED ***' "$log"; then
  exit 1
fi
exit 0
